//--- rv_core_macros.svh
// width and depth defines for the execute/memory/writeback pipeline
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// data path and address width
`define RV_XLEN 32

// register file index width, x0..x31
`define RV_REG_AW 5

// data memory depth in 32-bit words
// byte address bits above the word index wrap around
`define RV_DMEM_WORDS 256

`endif

//--- rv_core_pkg.sv
// shared types for the back half of the pipeline
// opcodes of the execute unit and load/store sizes
package rv_core_pkg;

    // decoded operation seen by execute
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_SLL   = 4'd5,
        OP_SRL   = 4'd6,
        OP_SRA   = 4'd7,
        OP_SLT   = 4'd8,  // signed compare
        OP_SLTU  = 4'd9,  // unsigned compare
        OP_LOAD  = 4'd10, // result is the effective address
        OP_STORE = 4'd11
    } ex_op_e;

    // load/store size, same codes as funct3 of LOAD/STORE
    // bit 2 marks zero extension, bits 1:0 the size
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_sel_e;

endpackage

//--- ex_alu.sv
// execute stage, combinational
// ALU functions, load/store address generation and store data
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module ex_alu (
    input  logic                  valid_i,
    input  rv_core_pkg::ex_op_e   op_i,
    input  rv_core_pkg::ls_sel_e  ls_sel_i,
    input  logic [`RV_XLEN-1:0]   pc_i,
    input  logic [`RV_XLEN-1:0]   src1_i,
    input  logic [`RV_XLEN-1:0]   src2_i,
    input  logic [`RV_XLEN-1:0]   imm_i,
    input  logic [`RV_REG_AW-1:0] rd_addr_i,
    output logic                  valid_o,
    output rv_core_pkg::ex_op_e   op_o,
    output rv_core_pkg::ls_sel_e  ls_sel_o,
    output logic [`RV_XLEN-1:0]   pc_o,
    output logic [`RV_REG_AW-1:0] rd_addr_o,
    output logic [`RV_XLEN-1:0]   result_o,
    output logic [`RV_XLEN-1:0]   store_data_o
);
    import rv_core_pkg::*;

    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] addr;
    logic                lt_s;
    logic                lt_u;

    assign shamt = src2_i[4:0]; // only low five bits count
    assign addr  = src1_i + imm_i;
    assign lt_s  = $signed(src1_i) < $signed(src2_i);
    assign lt_u  = src1_i < src2_i;

    always_comb begin
        case (op_i)
            OP_ADD:   result_o = src1_i + src2_i;
            OP_SUB:   result_o = src1_i - src2_i;
            OP_AND:   result_o = src1_i & src2_i;
            OP_OR:    result_o = src1_i | src2_i;
            OP_XOR:   result_o = src1_i ^ src2_i;
            OP_SLL:   result_o = src1_i << shamt;
            OP_SRL:   result_o = src1_i >> shamt;
            OP_SRA:   result_o = $signed(src1_i) >>> shamt;
            OP_SLT:   result_o = {{(`RV_XLEN-1){1'b0}}, lt_s};
            OP_SLTU:  result_o = {{(`RV_XLEN-1){1'b0}}, lt_u};
            OP_LOAD,
            OP_STORE: result_o = addr; // effective address
            default:  result_o = '0;
        endcase
    end

    // fields that just ride along to ex_mem
    assign valid_o      = valid_i;
    assign op_o         = op_i;
    assign ls_sel_o     = ls_sel_i;
    assign pc_o         = pc_i;
    assign rd_addr_o    = rd_addr_i;
    assign store_data_o = src2_i;

endmodule

//--- ex_mem.sv
// EX/MEM pipeline register
// async reset to zero, whole register holds on stall
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module ex_mem (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  stall_i,
    input  logic                  ex_valid_i,
    input  rv_core_pkg::ex_op_e   ex_op_i,
    input  rv_core_pkg::ls_sel_e  ex_ls_sel_i,
    input  logic [`RV_XLEN-1:0]   ex_pc_i,
    input  logic [`RV_REG_AW-1:0] ex_rd_addr_i,
    input  logic [`RV_XLEN-1:0]   ex_result_i,
    input  logic [`RV_XLEN-1:0]   ex_store_data_i,
    output logic                  mem_valid_o,
    output rv_core_pkg::ex_op_e   mem_op_o,
    output rv_core_pkg::ls_sel_e  mem_ls_sel_o,
    output logic [`RV_XLEN-1:0]   mem_pc_o,
    output logic [`RV_REG_AW-1:0] mem_rd_addr_o,
    output logic [`RV_XLEN-1:0]   mem_result_o,
    output logic [`RV_XLEN-1:0]   mem_store_data_o
);
    import rv_core_pkg::*;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_valid_o      <= 1'b0;
            mem_op_o         <= OP_ADD; // encodes as zero
            mem_ls_sel_o     <= LS_B;
            mem_pc_o         <= '0;
            mem_rd_addr_o    <= '0;
            mem_result_o     <= '0;
            mem_store_data_o <= '0;
        end else if (!stall_i) begin // stalled edge keeps everything
            mem_valid_o      <= ex_valid_i;
            mem_op_o         <= ex_op_i;
            mem_ls_sel_o     <= ex_ls_sel_i;
            mem_pc_o         <= ex_pc_i;
            mem_rd_addr_o    <= ex_rd_addr_i;
            mem_result_o     <= ex_result_i;
            mem_store_data_o <= ex_store_data_i;
        end
    end

    // an unknown valid would poison both the store enable and the write strobe
    a_valid_known: assert property (
        @(posedge clk) disable iff (!arst_n_i) !$isunknown(mem_valid_o)
    ) else $error("ex_mem: mem_valid_o is X after reset");

endmodule

//--- mem_access.sv
// memory stage: word-organised data memory with byte enables
// synchronous read, sized stores, and the MEM/WB field register
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module mem_access (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  stall_i,
    input  logic                  mem_valid_i,
    input  rv_core_pkg::ex_op_e   mem_op_i,
    input  rv_core_pkg::ls_sel_e  mem_ls_sel_i,
    input  logic [`RV_XLEN-1:0]   mem_pc_i,
    input  logic [`RV_REG_AW-1:0] mem_rd_addr_i,
    input  logic [`RV_XLEN-1:0]   mem_result_i,
    input  logic [`RV_XLEN-1:0]   mem_store_data_i,
    output logic                  wb_valid_o,
    output rv_core_pkg::ex_op_e   wb_op_o,
    output rv_core_pkg::ls_sel_e  wb_ls_sel_o,
    output logic [`RV_XLEN-1:0]   wb_pc_o,
    output logic [`RV_REG_AW-1:0] wb_rd_addr_o,
    output logic [`RV_XLEN-1:0]   wb_result_o,
    output logic [1:0]            wb_offset_o,
    output logic [`RV_XLEN-1:0]   rdata_o
);
    import rv_core_pkg::*;

    localparam int NLANES = `RV_XLEN / 8;
    localparam int IDX_W  = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
    logic [IDX_W-1:0]    word_idx;
    logic [1:0]          offset;
    logic [NLANES-1:0]   base_be;
    logic [NLANES-1:0]   byte_en;
    logic [`RV_XLEN-1:0] wdata;
    logic                st_en;
    logic                ld_en;
    logic                is_mem;

    assign word_idx = mem_result_i[2 +: IDX_W]; // upper address bits wrap
    assign offset   = mem_result_i[1:0];
    assign is_mem   = (mem_op_i == OP_LOAD) || (mem_op_i == OP_STORE);
    assign st_en    = mem_valid_i && !stall_i && (mem_op_i == OP_STORE);
    assign ld_en    = mem_valid_i && (mem_op_i == OP_LOAD);

    always_comb begin
        case (mem_ls_sel_i)
            LS_H, LS_HU: base_be = NLANES'(2'b11);
            LS_W:        base_be = {NLANES{1'b1}};
            default:     base_be = NLANES'(1'b1);
        endcase
    end

    // move the store data up to its byte lane
    assign byte_en = base_be << offset;
    assign wdata   = mem_store_data_i << {offset, 3'b000};

    always_ff @(posedge clk) begin
        if (st_en) begin
            for (int i = 0; i < NLANES; i++) begin
                if (byte_en[i]) begin
                    dmem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o   <= 1'b0;
            wb_op_o      <= OP_ADD;
            wb_ls_sel_o  <= LS_B;
            wb_pc_o      <= '0;
            wb_rd_addr_o <= '0;
            wb_result_o  <= '0;
            wb_offset_o  <= '0;
            rdata_o      <= '0;
        end else if (!stall_i) begin
            wb_valid_o   <= mem_valid_i;
            wb_op_o      <= mem_op_i;
            wb_ls_sel_o  <= mem_ls_sel_i;
            wb_pc_o      <= mem_pc_i;
            wb_rd_addr_o <= mem_rd_addr_i;
            wb_result_o  <= mem_result_i;
            wb_offset_o  <= offset;
            if (ld_en) begin
                rdata_o <= dmem[word_idx]; // whole word, aligned later
            end
        end
    end

    // misaligned accesses are not supported in hardware
    a_half_align: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (mem_valid_i && is_mem && (mem_ls_sel_i inside {LS_H, LS_HU}))
            |-> (mem_result_i[0] == 1'b0)
    ) else $error("mem_access: misaligned halfword access");

    a_word_align: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (mem_valid_i && is_mem && (mem_ls_sel_i == LS_W)) |-> (mem_result_i[1:0] == 2'b00)
    ) else $error("mem_access: misaligned word access");

endmodule

//--- mem_wb.sv
// writeback side: load alignment and sign/zero extension
// plus the registered register-file write port
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module mem_wb (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  stall_i,
    input  logic                  wb_valid_i,
    input  rv_core_pkg::ex_op_e   wb_op_i,
    input  rv_core_pkg::ls_sel_e  wb_ls_sel_i,
    input  logic [`RV_XLEN-1:0]   wb_pc_i,
    input  logic [`RV_REG_AW-1:0] wb_rd_addr_i,
    input  logic [`RV_XLEN-1:0]   wb_result_i,
    input  logic [1:0]            wb_offset_i,
    input  logic [`RV_XLEN-1:0]   rdata_i,
    output logic                  wb_we_o,
    output logic [`RV_REG_AW-1:0] wb_addr_o,
    output logic [`RV_XLEN-1:0]   wb_data_o,
    output logic [`RV_XLEN-1:0]   wb_pc_o
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] shifted;
    logic [`RV_XLEN-1:0] load_val;
    logic [`RV_XLEN-1:0] wdata;

    // addressed byte/halfword down to bit 0
    assign shifted = rdata_i >> {wb_offset_i, 3'b000};

    always_comb begin
        case (wb_ls_sel_i)
            LS_B:    load_val = {{(`RV_XLEN-8){shifted[7]}}, shifted[7:0]};
            LS_H:    load_val = {{(`RV_XLEN-16){shifted[15]}}, shifted[15:0]};
            LS_BU:   load_val = {{(`RV_XLEN-8){1'b0}}, shifted[7:0]};
            LS_HU:   load_val = {{(`RV_XLEN-16){1'b0}}, shifted[15:0]};
            default: load_val = shifted; // LS_W
        endcase
    end

    assign wdata = (wb_op_i == OP_LOAD) ? load_val : wb_result_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_we_o   <= 1'b0;
            wb_addr_o <= '0;
            wb_data_o <= '0;
            wb_pc_o   <= '0;
        end else if (stall_i) begin
            wb_we_o <= 1'b0; // no strobe after a stalled edge
        end else begin
            wb_we_o   <= wb_valid_i && (wb_op_i != OP_STORE);
            wb_addr_o <= wb_rd_addr_i;
            wb_data_o <= wdata;
            wb_pc_o   <= wb_pc_i;
        end
    end

    a_no_we_after_stall: assert property (
        @(posedge clk) disable iff (!arst_n_i) $past(stall_i) |-> !wb_we_o
    ) else $error("mem_wb: write strobe after a stalled edge");

endmodule

//--- ex_mem_wb_top.sv
// top level of the back half of the pipeline
// execute, EX/MEM register, memory stage and writeback
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module ex_mem_wb_top (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  stall_i,
    input  logic                  valid_i,
    input  rv_core_pkg::ex_op_e   op_i,
    input  rv_core_pkg::ls_sel_e  ls_sel_i,
    input  logic [`RV_XLEN-1:0]   pc_i,
    input  logic [`RV_XLEN-1:0]   src1_i,
    input  logic [`RV_XLEN-1:0]   src2_i,
    input  logic [`RV_XLEN-1:0]   imm_i,
    input  logic [`RV_REG_AW-1:0] rd_addr_i,
    output logic                  wb_we_o,
    output logic [`RV_REG_AW-1:0] wb_addr_o,
    output logic [`RV_XLEN-1:0]   wb_data_o,
    output logic [`RV_XLEN-1:0]   wb_pc_o
);
    import rv_core_pkg::*;

    // execute -> ex_mem
    logic                  ex_valid;
    ex_op_e                ex_op;
    ls_sel_e               ex_ls_sel;
    logic [`RV_XLEN-1:0]   ex_pc;
    logic [`RV_REG_AW-1:0] ex_rd_addr;
    logic [`RV_XLEN-1:0]   ex_result;
    logic [`RV_XLEN-1:0]   ex_store_data;

    // ex_mem -> memory stage
    logic                  mem_valid;
    ex_op_e                mem_op;
    ls_sel_e               mem_ls_sel;
    logic [`RV_XLEN-1:0]   mem_pc;
    logic [`RV_REG_AW-1:0] mem_rd_addr;
    logic [`RV_XLEN-1:0]   mem_result;
    logic [`RV_XLEN-1:0]   mem_store_data;

    // memory stage -> writeback
    logic                  wb_valid;
    ex_op_e                wb_op;
    ls_sel_e               wb_ls_sel;
    logic [`RV_XLEN-1:0]   wb_pc;
    logic [`RV_REG_AW-1:0] wb_rd_addr;
    logic [`RV_XLEN-1:0]   wb_result;
    logic [1:0]            wb_offset;
    logic [`RV_XLEN-1:0]   rdata;

    ex_alu u_ex_alu (
        .valid_i      (valid_i),
        .op_i         (op_i),
        .ls_sel_i     (ls_sel_i),
        .pc_i         (pc_i),
        .src1_i       (src1_i),
        .src2_i       (src2_i),
        .imm_i        (imm_i),
        .rd_addr_i    (rd_addr_i),
        .valid_o      (ex_valid),
        .op_o         (ex_op),
        .ls_sel_o     (ex_ls_sel),
        .pc_o         (ex_pc),
        .rd_addr_o    (ex_rd_addr),
        .result_o     (ex_result),
        .store_data_o (ex_store_data)
    );

    ex_mem u_ex_mem (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .stall_i          (stall_i),
        .ex_valid_i       (ex_valid),
        .ex_op_i          (ex_op),
        .ex_ls_sel_i      (ex_ls_sel),
        .ex_pc_i          (ex_pc),
        .ex_rd_addr_i     (ex_rd_addr),
        .ex_result_i      (ex_result),
        .ex_store_data_i  (ex_store_data),
        .mem_valid_o      (mem_valid),
        .mem_op_o         (mem_op),
        .mem_ls_sel_o     (mem_ls_sel),
        .mem_pc_o         (mem_pc),
        .mem_rd_addr_o    (mem_rd_addr),
        .mem_result_o     (mem_result),
        .mem_store_data_o (mem_store_data)
    );

    mem_access u_mem_access (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .stall_i          (stall_i),
        .mem_valid_i      (mem_valid),
        .mem_op_i         (mem_op),
        .mem_ls_sel_i     (mem_ls_sel),
        .mem_pc_i         (mem_pc),
        .mem_rd_addr_i    (mem_rd_addr),
        .mem_result_i     (mem_result),
        .mem_store_data_i (mem_store_data),
        .wb_valid_o       (wb_valid),
        .wb_op_o          (wb_op),
        .wb_ls_sel_o      (wb_ls_sel),
        .wb_pc_o          (wb_pc),
        .wb_rd_addr_o     (wb_rd_addr),
        .wb_result_o      (wb_result),
        .wb_offset_o      (wb_offset),
        .rdata_o          (rdata)
    );

    mem_wb u_mem_wb (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .stall_i      (stall_i),
        .wb_valid_i   (wb_valid),
        .wb_op_i      (wb_op),
        .wb_ls_sel_i  (wb_ls_sel),
        .wb_pc_i      (wb_pc),
        .wb_rd_addr_i (wb_rd_addr),
        .wb_result_i  (wb_result),
        .wb_offset_i  (wb_offset),
        .rdata_i      (rdata),
        .wb_we_o      (wb_we_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .wb_pc_o      (wb_pc_o)
    );

endmodule

//--- tb_clk_gen.sv
// testbench clock and power-on reset
// 8 ns clock, reset held low for the first 10 cycles
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o; // 125 MHz
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1; // release away from the active edge
    end

endmodule

//--- tb_checker.sv
// writeback monitor for the testbench
// expected writeback queue, field compares, latency, per-test and final counts
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module tb_checker (
    input logic                  clk,
    input logic                  arst_n_i,
    input logic                  stall_i,
    input logic                  wb_we_i,
    input logic [`RV_REG_AW-1:0] wb_addr_i,
    input logic [`RV_XLEN-1:0]   wb_data_i,
    input logic [`RV_XLEN-1:0]   wb_pc_i
);

    logic [`RV_REG_AW-1:0] exp_addr_q [$];
    logic [`RV_XLEN-1:0]   exp_data_q [$];
    logic [`RV_XLEN-1:0]   exp_pc_q [$];
    int                    exp_edge_q [$]; // unstalled edge count at issue
    logic                  stall_seen;
    int                    edge_cnt = 0;
    int                    latency;
    int                    err_cnt = 0;
    int                    wb_cnt = 0;
    int                    err_mark = 0;
    int                    wb_mark = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;

    function automatic int pending();
        return exp_addr_q.size();
    endfunction

    task automatic push_expect(input logic [`RV_REG_AW-1:0] addr,
                               input logic [`RV_XLEN-1:0] data,
                               input logic [`RV_XLEN-1:0] pc);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
        exp_pc_q.push_back(pc);
        exp_edge_q.push_back(edge_cnt);
    endtask

    task automatic compare_value(input string name, input logic [`RV_XLEN-1:0] exp,
                                 input logic [`RV_XLEN-1:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic drop_leftovers();
        err_cnt++;
        $display("%0t: %0d expected writebacks never arrived", $time, exp_addr_q.size());
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_pc_q.delete();
        exp_edge_q.delete();
    endtask

    // stall level and unstalled edge count at the last rising edge
    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stall_seen <= 1'b0;
            edge_cnt   <= 0;
        end else begin
            stall_seen <= stall_i;
            if (!stall_i) begin
                edge_cnt <= edge_cnt + 1;
            end
        end
    end

    // outputs settle after the rising edge and are sampled on the falling one
    always @(negedge clk) begin
        if (!arst_n_i) begin
            if (wb_we_i !== 1'b0) begin
                err_cnt++;
                $display("%0t: write strobe is not low during reset", $time);
            end
        end else if (wb_we_i === 1'b1) begin
            if (stall_seen) begin
                err_cnt++;
                $display("%0t: write strobe right after a stalled edge", $time);
            end
            if (exp_addr_q.size() == 0) begin
                err_cnt++;
                $display("%0t: write strobe with no writeback expected", $time);
            end else begin
                latency = edge_cnt - exp_edge_q.pop_front();
                if (latency != 3) begin
                    err_cnt++;
                    $display("%0t: writeback came %0d unstalled edges after issue instead of 3",
                             $time, latency);
                end
                compare_value("wb_addr_o", {27'd0, exp_addr_q.pop_front()}, {27'd0, wb_addr_i});
                compare_value("wb_data_o", exp_data_q.pop_front(), wb_data_i);
                compare_value("wb_pc_o", exp_pc_q.pop_front(), wb_pc_i);
                wb_cnt++;
            end
        end
    end

    task automatic test_done(input string name);
        int errs;
        errs = err_cnt - err_mark;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("test %-13s %s (%0d writebacks, %0d errors)", name,
                 (errs == 0) ? "ok" : "FAILED", wb_cnt - wb_mark, errs);
        err_mark = err_cnt;
        wb_mark  = wb_cnt;
    endtask

    task automatic summary();
        $display("summary: %0d tests, %0d failed, %0d writebacks checked, %0d errors",
                 tests_run, tests_failed, wb_cnt, err_cnt);
    endtask

endmodule

//--- tb_top.sv
// testbench top: DUT, random stimulus with a reference model, watchdog
// tests run in order: reset, alu, load/store, store/bubble, stall mix
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module tb_top;
    import rv_core_pkg::*;

    localparam int N_INIT    = 16; // words in the 64-byte window
    localparam int N_ALU     = 200;
    localparam int N_LDST    = 150; // store plus load per step
    localparam int N_BUB     = 150;
    localparam int N_MIX     = 250;
    localparam int TOTAL_OPS = N_INIT + N_ALU + 2 * N_LDST + N_BUB + N_MIX;
    localparam int WDOG_NS   = TOTAL_OPS * 8 * 4 + 2000;

    logic                  clk;
    logic                  arst_n;
    logic                  stall;
    logic                  valid;
    ex_op_e                op;
    ls_sel_e               ls_sel;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   src1;
    logic [`RV_XLEN-1:0]   src2;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_REG_AW-1:0] rd_addr;
    logic                  wb_we;
    logic [`RV_REG_AW-1:0] wb_addr;
    logic [`RV_XLEN-1:0]   wb_data;
    logic [`RV_XLEN-1:0]   wb_pc;
    integer                seed = 44387;
    logic [7:0]            mdl_mem [64]; // model of the address window
    logic [`RV_XLEN-1:0]   pc_cnt;

    tb_clk_gen u_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

    ex_mem_wb_top DUT (
        .clk(clk), .arst_n_i(arst_n), .stall_i(stall), .valid_i(valid), .op_i(op),
        .ls_sel_i(ls_sel), .pc_i(pc), .src1_i(src1), .src2_i(src2), .imm_i(imm),
        .rd_addr_i(rd_addr), .wb_we_o(wb_we), .wb_addr_o(wb_addr), .wb_data_o(wb_data),
        .wb_pc_o(wb_pc)
    );

    tb_checker u_checker (
        .clk(clk), .arst_n_i(arst_n), .stall_i(stall), .wb_we_i(wb_we),
        .wb_addr_i(wb_addr), .wb_data_i(wb_data), .wb_pc_i(wb_pc)
    );

    function automatic logic [31:0] alu_ref(input ex_op_e f, input logic [31:0] a,
                                            input logic [31:0] b);
        case (f)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    // little endian, sign or zero extended by size
    function automatic logic [31:0] load_ref(input ls_sel_e s, input logic [5:0] a);
        logic [15:0] h;
        h = {mdl_mem[a + 6'd1], mdl_mem[a]};
        case (s)
            LS_B:    return {{24{h[7]}}, h[7:0]};
            LS_BU:   return {24'd0, h[7:0]};
            LS_H:    return {{16{h[15]}}, h};
            LS_HU:   return {16'd0, h};
            default: return {mdl_mem[a + 6'd3], mdl_mem[a + 6'd2], h};
        endcase
    endfunction

    function automatic ls_sel_e pick_ls(input logic store_only);
        logic [31:0] r;
        r = $random(seed);
        if (store_only) return (r % 3 == 0) ? LS_B : ((r % 3 == 1) ? LS_H : LS_W);
        case (r % 5)
            0:       return LS_B;
            1:       return LS_H;
            2:       return LS_W;
            3:       return LS_BU;
            default: return LS_HU;
        endcase
    endfunction

    function automatic logic [5:0] rand_addr(input ls_sel_e s);
        logic [31:0] r;
        r = $random(seed);
        if (s == LS_W) return {r[5:2], 2'b00};
        if (s == LS_H || s == LS_HU) return {r[5:1], 1'b0};
        return r[5:0];
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            stall = 1'b0;
            valid = 1'b0;
        end
    endtask

    // random stall cycles first, then the operation itself on an unstalled edge
    task automatic send(input int stall_pct, input logic v, input ex_op_e f, input ls_sel_e s,
                        input logic [31:0] a, input logic [31:0] b, input logic [31:0] i,
                        input logic [4:0] rd);
        logic [31:0] r;
        logic [31:0] ea;
        while (($unsigned($random(seed)) % 100) < stall_pct) begin
            @(negedge clk);
            r = $random(seed);
            stall = 1'b1;
            valid = r[0]; // ignored while stalled
            op    = ex_op_e'(r[7:4] % 4'd12);
            src1  = $random(seed);
            imm   = $random(seed);
        end
        @(negedge clk);
        stall   = 1'b0;
        valid   = v;
        op      = f;
        ls_sel  = s;
        pc      = pc_cnt;
        src1    = a;
        src2    = b;
        imm     = i;
        rd_addr = rd;
        ea      = a + i;
        if (v && f == OP_STORE) begin
            mdl_mem[ea[5:0]] = b[7:0];
            if (s != LS_B) mdl_mem[ea[5:0] + 6'd1] = b[15:8];
            if (s == LS_W) mdl_mem[ea[5:0] + 6'd2] = b[23:16];
            if (s == LS_W) mdl_mem[ea[5:0] + 6'd3] = b[31:24];
        end else if (v && f == OP_LOAD) begin
            u_checker.push_expect(rd, load_ref(s, ea[5:0]), pc_cnt);
        end else if (v) begin
            u_checker.push_expect(rd, alu_ref(f, a, b), pc_cnt);
        end
        pc_cnt = pc_cnt + 32'd4;
    endtask

    task automatic mem_op(input int stall_pct, input logic is_store, input ls_sel_e s,
                          input logic [5:0] a);
        logic [31:0] base;
        logic [31:0] r;
        ex_op_e      f;
        base = $random(seed);
        r    = $random(seed);
        f    = OP_LOAD;
        if (is_store) f = OP_STORE;
        send(stall_pct, 1'b1, f, s, base, $random(seed), {26'd0, a} - base, r[4:0]);
    endtask

    task automatic alu_op(input int stall_pct);
        logic [31:0] r;
        r = $random(seed);
        send(stall_pct, 1'b1, ex_op_e'(4'(r % 10)), LS_W, $random(seed), $random(seed),
             $random(seed), r[12:8]);
    endtask

    // store, then a load that may hit the same word on the very next edge
    task automatic ldst_step(input int stall_pct);
        ls_sel_e     s;
        logic [5:0]  a;
        logic [5:0]  b;
        logic [31:0] r;
        s = pick_ls(1'b1);
        a = rand_addr(s);
        mem_op(stall_pct, 1'b1, s, a);
        r = $random(seed);
        s = pick_ls(1'b0);
        b = rand_addr(s);
        if (r[0]) begin
            b[5:2] = a[5:2];
            mem_op(0, 1'b0, s, b);
        end else begin
            mem_op(stall_pct, 1'b0, s, b);
        end
    endtask

    task automatic mixed_step(input int stall_pct, input int quiet_pct);
        logic [31:0] r;
        ls_sel_e     s;
        r = $random(seed);
        if ((r % 100) < quiet_pct && r[16]) begin
            s = pick_ls(1'b1);
            mem_op(stall_pct, 1'b1, s, rand_addr(s));
        end else if ((r % 100) < quiet_pct) begin
            send(stall_pct, 1'b0, ex_op_e'(r[23:20] % 4'd12), pick_ls(1'b0), $random(seed),
                 $random(seed), $random(seed), r[12:8]); // bubble
        end else if (r[17]) begin
            alu_op(stall_pct);
        end else begin
            s = pick_ls(1'b0);
            mem_op(stall_pct, 1'b0, s, rand_addr(s));
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (u_checker.pending() != 0 && waited < 12) begin
            idle(1);
            waited++;
        end
        if (u_checker.pending() != 0) u_checker.drop_leftovers();
        idle(3);
    endtask

    initial begin
        stall   = 1'b0;
        valid   = 1'b0;
        op      = OP_ADD;
        ls_sel  = LS_W;
        pc      = '0;
        src1    = '0;
        src2    = '0;
        imm     = '0;
        rd_addr = '0;
        pc_cnt  = 32'h0000_1000;
        wait (arst_n === 1'b1);
        idle(8);
        u_checker.test_done("reset");
        for (int i = 0; i < N_ALU; i++) alu_op(0);
        drain();
        u_checker.test_done("alu");
        for (int w = 0; w < N_INIT; w++) mem_op(0, 1'b1, LS_W, 6'(w * 4));
        for (int i = 0; i < N_LDST; i++) ldst_step(20);
        drain();
        u_checker.test_done("load_store");
        for (int i = 0; i < N_BUB; i++) mixed_step(20, 70);
        drain();
        u_checker.test_done("store_bubble");
        for (int i = 0; i < N_MIX; i++) mixed_step(20, 40);
        drain();
        u_checker.test_done("stall_mix");
        u_checker.summary();
        if (u_checker.err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // bound on the whole run, four clocks per operation plus slack
    initial begin
        #(WDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WDOG_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
rv_core_pkg.sv
ex_alu.sv
ex_mem.sv
mem_access.sv
mem_wb.sv
ex_mem_wb_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, result taken from sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_top -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation ok"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
